// File: source/simd_alu_pkg.sv
`default_nettype none

package simd_alu_pkg;

  // data word width, fixed by the four byte lane structure
  localparam int XLEN = 32;
  // number of byte lanes in one word
  localparam int NUM_BYTES = XLEN / 8;
  // adder width with one separator bit below every byte
  localparam int SEP_WIDTH = XLEN + NUM_BYTES;

  ////////////////////////////////////////////////////////////
  // operations and lane modes
  ////////////////////////////////////////////////////////////

  typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_EQ,
    ALU_NE,
    ALU_GTS,
    ALU_GTU,
    ALU_GES,
    ALU_GEU,
    ALU_LTS,
    ALU_LTU,
    ALU_LES,
    ALU_LEU,
    ALU_SLTS,
    ALU_SLTU,
    ALU_MIN,
    ALU_MINU,
    ALU_MAX,
    ALU_MAXU,
    ALU_RELU,
    ALU_MAC32,
    ALU_MAC16
  } alu_op_e;

  // same encoding as the core decoder, 2'b01 is unused
  typedef enum logic [1:0] {
    VEC_MODE32 = 2'b00,
    VEC_MODE16 = 2'b10,
    VEC_MODE8  = 2'b11
  } vec_mode_e;

  ////////////////////////////////////////////////////////////
  // lane views of one data word
  ////////////////////////////////////////////////////////////

  typedef union packed {
    logic [XLEN-1:0]            word;
    logic [1:0][XLEN/2-1:0]     halves;
    logic [NUM_BYTES-1:0][7:0]  bytes;
  } simd_word_u;

  // one bit per byte, a wider lane sets every bit it covers
  typedef logic [NUM_BYTES-1:0] lane_mask_t;

endpackage

`default_nettype wire

// File: source/simd_alu_stage_if.sv
`timescale 1ns/10ps
`default_nettype none

// one issued operation travelling from issue to accumulate stage
interface simd_alu_stage_if;
  import simd_alu_pkg::*;

  // handshake, transfer when both high
  logic       valid;
  logic       ready;
  // payload, held stable while valid waits for ready
  alu_op_e    op;
  vec_mode_e  vec_mode;
  simd_word_u result;
  logic [XLEN-1:0] prod0;
  logic [XLEN-1:0] prod1;
  logic [XLEN-1:0] acc;
  logic       cmp;

  modport issue (
    output valid, op, vec_mode, result, prod0, prod1, acc, cmp,
    input  ready
  );

  modport accum (
    output ready,
    input  valid, op, vec_mode, result, prod0, prod1, acc, cmp
  );

endinterface

`default_nettype wire

// File: source/simd_adder.sv
`timescale 1ns/10ps
`default_nettype none

module simd_adder (
  input  simd_alu_pkg::alu_op_e    op_i,
  input  simd_alu_pkg::vec_mode_e  vec_mode_i,
  input  simd_alu_pkg::simd_word_u operand_a_i,
  input  simd_alu_pkg::simd_word_u operand_b_i,
  output simd_alu_pkg::simd_word_u sum_o
);
  import simd_alu_pkg::*;

  logic                  is_sub;
  logic [NUM_BYTES-1:0]  lane_start;
  logic [XLEN-1:0]       op_b_eff;
  logic [SEP_WIDTH-1:0]  wide_a;
  logic [SEP_WIDTH-1:0]  wide_b;
  logic [SEP_WIDTH-1:0]  wide_sum;

  assign is_sub = (op_i == ALU_SUB);

  // two's complement subtract, carry-in comes from the separators
  assign op_b_eff = is_sub ? ~operand_b_i.word : operand_b_i.word;

  // bytes that open a new lane in the current mode
  always_comb begin
    case (vec_mode_i)
      VEC_MODE8:  lane_start = 4'b1111;
      VEC_MODE16: lane_start = 4'b0101;
      default:    lane_start = 4'b0001;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // separator insertion
  ////////////////////////////////////////////////////////////

  // byte i sits at [9*i+8:9*i+1], its separator at bit 9*i
  // inside a lane: a=1, b=0 passes the carry of the byte below
  // lane start, add: a=0, b=0 kills any carry from the lane below
  // lane start, sub: a=1, b=1 forces the +1 of the negation
  always_comb begin
    for (int i = 0; i < NUM_BYTES; i++) begin
      wide_a[9*i]       = ~(lane_start[i] & ~is_sub);
      wide_b[9*i]       = lane_start[i] & is_sub;
      wide_a[9*i+1 +: 8] = operand_a_i.bytes[i];
      wide_b[9*i+1 +: 8] = op_b_eff[8*i +: 8];
    end
  end

  // carry out of the top lane is dropped, lanes wrap
  assign wide_sum = wide_a + wide_b;

  // strip the separators again
  always_comb begin
    for (int i = 0; i < NUM_BYTES; i++) begin
      sum_o.bytes[i] = wide_sum[9*i+1 +: 8];
    end
  end

endmodule

`default_nettype wire

// File: source/simd_compare.sv
`timescale 1ns/10ps
`default_nettype none

module simd_compare (
  input  simd_alu_pkg::alu_op_e    op_i,
  input  simd_alu_pkg::vec_mode_e  vec_mode_i,
  input  simd_alu_pkg::simd_word_u operand_a_i,
  input  simd_alu_pkg::simd_word_u operand_b_i,
  output simd_alu_pkg::lane_mask_t cmp_mask_o,
  output simd_alu_pkg::simd_word_u minmax_o
);
  import simd_alu_pkg::*;

  logic        signed_op;
  logic        do_min;
  lane_mask_t  lane_top;
  lane_mask_t  byte_signed;
  lane_mask_t  eq_byte;
  lane_mask_t  gt_byte;
  logic [1:0]  eq_half;
  logic [1:0]  gt_half;
  logic        eq_word;
  logic        gt_word;
  lane_mask_t  is_equal;
  lane_mask_t  is_greater;
  lane_mask_t  sel_a;

  always_comb begin
    case (op_i)
      ALU_GTS, ALU_GES, ALU_LTS, ALU_LES, ALU_SLTS, ALU_MIN, ALU_MAX: signed_op = 1'b1;
      default: signed_op = 1'b0;
    endcase
  end

  // top byte of each lane carries the sign
  always_comb begin
    case (vec_mode_i)
      VEC_MODE8:  lane_top = 4'b1111;
      VEC_MODE16: lane_top = 4'b1010;
      default:    lane_top = 4'b1000;
    endcase
  end

  assign byte_signed = lane_top & {NUM_BYTES{signed_op}};

  ////////////////////////////////////////////////////////////
  // per byte equal / greater
  ////////////////////////////////////////////////////////////

  // a 9th bit holds the sign only where the byte tops a signed lane
  always_comb begin
    for (int i = 0; i < NUM_BYTES; i++) begin
      eq_byte[i] = (operand_a_i.bytes[i] == operand_b_i.bytes[i]);
      gt_byte[i] = $signed({operand_a_i.bytes[i][7] & byte_signed[i], operand_a_i.bytes[i]}) >
                   $signed({operand_b_i.bytes[i][7] & byte_signed[i], operand_b_i.bytes[i]});
    end
  end

  // chain bytes into halves, halves into the word
  // upper byte decides, lower byte only when upper bytes tie
  always_comb begin
    for (int h = 0; h < 2; h++) begin
      eq_half[h] = eq_byte[2*h+1] & eq_byte[2*h];
      gt_half[h] = gt_byte[2*h+1] | (eq_byte[2*h+1] & gt_byte[2*h]);
    end
  end

  assign eq_word = eq_half[1] & eq_half[0];
  assign gt_word = gt_half[1] | (eq_half[1] & gt_half[0]);

  // spread lane results over the byte bits they cover
  always_comb begin
    case (vec_mode_i)
      VEC_MODE8: begin
        is_equal   = eq_byte;
        is_greater = gt_byte;
      end
      VEC_MODE16: begin
        is_equal   = {{2{eq_half[1]}}, {2{eq_half[0]}}};
        is_greater = {{2{gt_half[1]}}, {2{gt_half[0]}}};
      end
      default: begin
        is_equal   = {NUM_BYTES{eq_word}};
        is_greater = {NUM_BYTES{gt_word}};
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // comparison mask and min/max select
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (op_i)
      ALU_EQ:                             cmp_mask_o = is_equal;
      ALU_NE:                             cmp_mask_o = ~is_equal;
      ALU_GTS, ALU_GTU:                   cmp_mask_o = is_greater;
      ALU_GES, ALU_GEU:                   cmp_mask_o = is_greater | is_equal;
      ALU_LTS, ALU_LTU, ALU_SLTS, ALU_SLTU: cmp_mask_o = ~(is_greater | is_equal);
      ALU_LES, ALU_LEU:                   cmp_mask_o = ~is_greater;
      default:                            cmp_mask_o = '0;
    endcase
  end

  // max keeps a where a > b, min keeps a where a <= b
  assign do_min = (op_i == ALU_MIN) || (op_i == ALU_MINU);
  assign sel_a  = is_greater ^ {NUM_BYTES{do_min}};

  always_comb begin
    for (int i = 0; i < NUM_BYTES; i++) begin
      minmax_o.bytes[i] = sel_a[i] ? operand_a_i.bytes[i] : operand_b_i.bytes[i];
    end
  end

endmodule

`default_nettype wire

// File: source/simd_issue_stage.sv
`timescale 1ns/10ps
`default_nettype none

module simd_issue_stage (
  input  logic                            clk,
  input  logic                            arst_n_i,
  input  logic                            valid_i,
  output logic                            ready_o,
  input  simd_alu_pkg::alu_op_e           op_i,
  input  simd_alu_pkg::vec_mode_e         vec_mode_i,
  input  logic [simd_alu_pkg::XLEN-1:0]   operand_a_i,
  input  logic [simd_alu_pkg::XLEN-1:0]   operand_b_i,
  input  logic [simd_alu_pkg::XLEN-1:0]   operand_c_i,
  simd_alu_stage_if.issue                 stage
);
  import simd_alu_pkg::*;

  simd_word_u      op_a;
  simd_word_u      op_b;
  simd_word_u      sum;
  simd_word_u      minmax;
  simd_word_u      cmp_expand;
  simd_word_u      relu_res;
  simd_word_u      result_d;
  lane_mask_t      cmp_mask;
  logic [XLEN-1:0] mul_word;
  logic [XLEN-1:0] mul_lo;
  logic [XLEN-1:0] mul_hi;
  logic            accept;

  assign op_a = operand_a_i;
  assign op_b = operand_b_i;

  simd_adder adder0 (
    .op_i        (op_i),
    .vec_mode_i  (vec_mode_i),
    .operand_a_i (op_a),
    .operand_b_i (op_b),
    .sum_o       (sum)
  );

  simd_compare compare0 (
    .op_i        (op_i),
    .vec_mode_i  (vec_mode_i),
    .operand_a_i (op_a),
    .operand_b_i (op_b),
    .cmp_mask_o  (cmp_mask),
    .minmax_o    (minmax)
  );

  ////////////////////////////////////////////////////////////
  // single cycle results
  ////////////////////////////////////////////////////////////

  // every mask bit fills its byte
  always_comb begin
    for (int i = 0; i < NUM_BYTES; i++) begin
      cmp_expand.bytes[i] = {8{cmp_mask[i]}};
    end
  end

  // relu, lane width follows the vector mode
  always_comb begin
    relu_res = op_a;
    case (vec_mode_i)
      VEC_MODE8: begin
        for (int i = 0; i < NUM_BYTES; i++) begin
          if (op_a.bytes[i][7]) relu_res.bytes[i] = '0;
        end
      end
      VEC_MODE16: begin
        for (int h = 0; h < 2; h++) begin
          if (op_a.halves[h][XLEN/2-1]) relu_res.halves[h] = '0;
        end
      end
      default: begin
        if (op_a.word[XLEN-1]) relu_res.word = '0;
      end
    endcase
  end

  always_comb begin
    case (op_i)
      ALU_ADD, ALU_SUB: result_d = sum;
      ALU_AND:          result_d.word = op_a.word & op_b.word;
      ALU_OR:           result_d.word = op_a.word | op_b.word;
      ALU_XOR:          result_d.word = op_a.word ^ op_b.word;
      ALU_EQ, ALU_NE, ALU_GTS, ALU_GTU, ALU_GES, ALU_GEU,
      ALU_LTS, ALU_LTU, ALU_LES, ALU_LEU: result_d = cmp_expand;
      // scalar set-less-than, word compare lands in the top mask bit
      ALU_SLTS, ALU_SLTU: result_d.word = {{(XLEN-1){1'b0}}, cmp_mask[3]};
      ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU: result_d = minmax;
      ALU_RELU:         result_d = relu_res;
      // mac results are formed in the accumulate stage
      default:          result_d.word = '0;
    endcase
  end

  // signed products, low word only
  assign mul_word = $signed(op_a.word) * $signed(op_b.word);
  assign mul_lo   = $signed(op_a.halves[0]) * $signed(op_b.halves[0]);
  assign mul_hi   = $signed(op_a.halves[1]) * $signed(op_b.halves[1]);

  ////////////////////////////////////////////////////////////
  // pipeline register
  ////////////////////////////////////////////////////////////

  // free when empty or when the item moves on this cycle
  assign ready_o = ~stage.valid | stage.ready;
  assign accept  = valid_i & ready_o;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      stage.valid <= 1'b0;
    end else if (ready_o) begin
      stage.valid <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      stage.op       <= op_i;
      stage.vec_mode <= vec_mode_i;
      stage.result   <= result_d;
      stage.prod0    <= (op_i == ALU_MAC32) ? mul_word : mul_lo;
      stage.prod1    <= mul_hi;
      stage.acc      <= operand_c_i;
      stage.cmp      <= cmp_mask[3];
    end
  end

endmodule

`default_nettype wire

// File: source/simd_accumulate_stage.sv
`timescale 1ns/10ps
`default_nettype none

module simd_accumulate_stage (
  input  logic                          clk,
  input  logic                          arst_n_i,
  simd_alu_stage_if.accum               stage,
  output logic [simd_alu_pkg::XLEN-1:0] result_o,
  output logic                          cmp_o,
  output logic                          result_valid_o,
  input  logic                          result_ready_i
);
  import simd_alu_pkg::*;

  logic [XLEN-1:0] result_d;
  logic            transfer;

  ////////////////////////////////////////////////////////////
  // accumulate
  ////////////////////////////////////////////////////////////

  // all sums wrap modulo 2^32
  // mac16 is a dot product of both half lanes
  always_comb begin
    case (stage.op)
      ALU_MAC32: result_d = stage.acc + stage.prod0;
      ALU_MAC16: result_d = stage.acc + stage.prod0 + stage.prod1;
      default:   result_d = stage.result.word;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////

  // accept from issue when empty or when the consumer takes ours
  assign stage.ready = ~result_valid_o | result_ready_i;
  assign transfer    = stage.valid & stage.ready;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      result_valid_o <= 1'b0;
    end else if (stage.ready) begin
      result_valid_o <= stage.valid;
    end
  end

  // result held while the consumer stalls
  always_ff @(posedge clk) begin
    if (transfer) begin
      result_o <= result_d;
      cmp_o    <= stage.cmp;
    end
  end

endmodule

`default_nettype wire

// File: source/simd_alu_top.sv
`timescale 1ns/10ps
`default_nettype none

module simd_alu_top (
  input  logic                          clk,
  input  logic                          arst_n_i,
  // issue side
  input  logic                          valid_i,
  output logic                          ready_o,
  input  simd_alu_pkg::alu_op_e         op_i,
  input  simd_alu_pkg::vec_mode_e       vec_mode_i,
  input  logic [simd_alu_pkg::XLEN-1:0] operand_a_i,
  input  logic [simd_alu_pkg::XLEN-1:0] operand_b_i,
  input  logic [simd_alu_pkg::XLEN-1:0] operand_c_i,
  // result side
  output logic [simd_alu_pkg::XLEN-1:0] result_o,
  output logic                          cmp_o,
  output logic                          result_valid_o,
  input  logic                          result_ready_i
);

  ////////////////////////////////////////////////////////////
  // two stage pipeline
  ////////////////////////////////////////////////////////////

  // link between decode/multiply and accumulate/output
  simd_alu_stage_if stage_if0 ();

  // decode, single cycle ops, products
  simd_issue_stage issue_stage0 (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .valid_i     (valid_i),
    .ready_o     (ready_o),
    .op_i        (op_i),
    .vec_mode_i  (vec_mode_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .operand_c_i (operand_c_i),
    .stage       (stage_if0.issue)
  );

  // mac accumulate and result register
  simd_accumulate_stage accum_stage0 (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .stage          (stage_if0.accum),
    .result_o       (result_o),
    .cmp_o          (cmp_o),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i)
  );

endmodule

`default_nettype wire

// File: verification/tb_simd_alu_checks.svh
`ifndef TB_SIMD_ALU_CHECKS_SVH
`define TB_SIMD_ALU_CHECKS_SVH

////////////////////////////////////////////////////////////
// reference model
////////////////////////////////////////////////////////////

function automatic int lane_width(input simd_alu_pkg::vec_mode_e mode);
  case (mode)
    simd_alu_pkg::VEC_MODE8:  return 8;
    simd_alu_pkg::VEC_MODE16: return 16;
    default:                  return 32;
  endcase
endfunction

// sign bit of every lane in the mode
function automatic logic [31:0] lane_sign_bits(input simd_alu_pkg::vec_mode_e mode);
  case (mode)
    simd_alu_pkg::VEC_MODE8:  return 32'h8080_8080;
    simd_alu_pkg::VEC_MODE16: return 32'h8000_8000;
    default:                  return 32'h8000_0000;
  endcase
endfunction

// lane k of a word as a number, sign extended when asked
function automatic longint lane_value(input logic [31:0] w, input int k, input int width,
                                      input bit sgn);
  longint v;
  v = 0;
  for (int i = 0; i < width; i++) begin
    v[i] = w[k*width+i];
  end
  if (sgn && v[width-1]) v = v - (longint'(1) << width);
  return v;
endfunction

function automatic bit is_signed_op(input simd_alu_pkg::alu_op_e op);
  return op inside {ALU_GTS, ALU_GES, ALU_LTS, ALU_LES, ALU_SLTS, ALU_MIN, ALU_MAX};
endfunction

// vector compares and set-less-than report a top lane outcome on cmp_o
function automatic bit is_cmp_op(input simd_alu_pkg::alu_op_e op);
  return (op >= ALU_EQ) && (op <= ALU_SLTU);
endfunction

function automatic bit lane_outcome(input simd_alu_pkg::alu_op_e op, input longint x,
                                    input longint y);
  case (op)
    ALU_EQ:                               return x == y;
    ALU_NE:                               return x != y;
    ALU_GTS, ALU_GTU:                     return x > y;
    ALU_GES, ALU_GEU:                     return x >= y;
    ALU_LTS, ALU_LTU, ALU_SLTS, ALU_SLTU: return x < y;
    ALU_LES, ALU_LEU:                     return x <= y;
    default:                              return 1'b0;
  endcase
endfunction

// outcome of the top lane, which covers byte 3
function automatic logic model_cmp(input simd_alu_pkg::alu_op_e op,
                                   input simd_alu_pkg::vec_mode_e mode,
                                   input logic [31:0] a, input logic [31:0] b);
  int w;
  w = lane_width(mode);
  return lane_outcome(op, lane_value(a, 32/w-1, w, is_signed_op(op)),
                      lane_value(b, 32/w-1, w, is_signed_op(op)));
endfunction

function automatic simd_alu_pkg::simd_word_u model_result(input simd_alu_pkg::alu_op_e op,
    input simd_alu_pkg::vec_mode_e mode, input logic [31:0] a, input logic [31:0] b,
    input logic [31:0] c);
  simd_alu_pkg::simd_word_u r;
  int     w;
  bit     sgn;
  longint x;
  longint y;
  longint lane;
  longint p;
  r.word = '0;
  w = lane_width(mode);
  sgn = is_signed_op(op);
  // mac ignores the mode, products are signed and wrap at 2^32
  if (op == ALU_MAC32) begin
    p = lane_value(a, 0, 32, 1) * lane_value(b, 0, 32, 1);
    r.word = c + p[31:0];
    return r;
  end
  if (op == ALU_MAC16) begin
    p = lane_value(a, 0, 16, 1) * lane_value(b, 0, 16, 1)
      + lane_value(a, 1, 16, 1) * lane_value(b, 1, 16, 1);
    r.word = c + p[31:0];
    return r;
  end
  for (int k = 0; k < 32/w; k++) begin
    x = lane_value(a, k, w, sgn);
    y = lane_value(b, k, w, sgn);
    case (op)
      ALU_ADD:            lane = x + y;
      ALU_SUB:            lane = x - y;
      ALU_AND:            lane = x & y;
      ALU_OR:             lane = x | y;
      ALU_XOR:            lane = x ^ y;
      ALU_MIN, ALU_MINU:  lane = (x <= y) ? x : y;
      ALU_MAX, ALU_MAXU:  lane = (x >= y) ? x : y;
      ALU_RELU:           lane = x[w-1] ? 0 : x;
      ALU_SLTS, ALU_SLTU: lane = 0;
      // compare lanes become all ones or all zeros
      default:            lane = lane_outcome(op, x, y) ? -1 : 0;
    endcase
    for (int i = 0; i < w; i++) begin
      r.word[k*w+i] = lane[i];
    end
  end
  if (op == ALU_SLTS || op == ALU_SLTU) r.word = {31'b0, model_cmp(op, mode, a, b)};
  return r;
endfunction

////////////////////////////////////////////////////////////
// compare tasks
////////////////////////////////////////////////////////////

task automatic check_word(input string name, input simd_alu_pkg::simd_word_u got,
                          input simd_alu_pkg::simd_word_u exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED %s: got %h expected %h", name, got.word, exp.word);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
  end
endtask

`endif

// File: verification/tb_simd_alu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_simd_alu;
  import simd_alu_pkg::*;

  // random rows per op and mode, then 7 edge rows
  localparam int RAND_N = 8;
  localparam int ROWS = RAND_N + 7;
  localparam int BP_OPS = 6;
  // add/sub, logic+relu, compares in three modes, two mac groups
  localparam int NUM_OPS = (2*3 + 4*3 + 16*3 + 2) * ROWS + BP_OPS;
  localparam int TIMEOUT_CYCLES = 2 * NUM_OPS + 200;

  // one expected result, in issue order
  typedef struct packed {
    alu_op_e    op;
    vec_mode_e  mode;
    simd_word_u result;
    logic       cmp;
    logic       has_cmp;
    int         accepted;
  } expect_t;

  logic            clk;
  logic            arst_n;
  logic            valid_i;
  logic            ready_o;
  alu_op_e         op_i;
  vec_mode_e       vec_mode_i;
  logic [XLEN-1:0] operand_a_i;
  logic [XLEN-1:0] operand_b_i;
  logic [XLEN-1:0] operand_c_i;
  logic [XLEN-1:0] result_o;
  logic            cmp_o;
  logic            result_valid_o;
  logic            result_ready_i;

  int      errors = 0;
  int      checks = 0;
  int      cycle = 0;
  int      issued = 0;
  int      results_seen = 0;
  bit      check_latency = 1'b1;
  integer  seed;
  expect_t exp_q [$];

  // carry/borrow across every lane boundary, sign extremes for mac
  logic [XLEN-1:0] edge_a [5] = '{32'hFFFF_FFFF, 32'h0000_0000, 32'h8000_8000,
                                  32'h7FFF_7F7F, 32'h7FFF_FFFF};
  logic [XLEN-1:0] edge_b [5] = '{32'h0000_0001, 32'h0000_0001, 32'h8000_8000,
                                  32'h8080_8080, 32'h8000_0001};
  logic [XLEN-1:0] edge_c [5] = '{32'h0000_0000, 32'hFFFF_FFFF, 32'h7FFF_FFFF,
                                  32'h8000_0000, 32'h1234_5678};

  `include "tb_simd_alu_checks.svh"

  simd_alu_top dut0 (
    .clk            (clk),
    .arst_n_i       (arst_n),
    .valid_i        (valid_i),
    .ready_o        (ready_o),
    .op_i           (op_i),
    .vec_mode_i     (vec_mode_i),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .operand_c_i    (operand_c_i),
    .result_o       (result_o),
    .cmp_o          (cmp_o),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i)
  );

  always #10 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  ////////////////////////////////////////////////////////////
  // issue and result handling
  ////////////////////////////////////////////////////////////

  // one attempt, taken when ready_o is high before the next rising edge
  task automatic drive_op(input alu_op_e op, input vec_mode_e mode, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b, input logic [XLEN-1:0] c, output bit taken);
    expect_t e;
    valid_i = 1'b1;
    op_i = op;
    vec_mode_i = mode;
    operand_a_i = a;
    operand_b_i = b;
    operand_c_i = c;
    #1;
    taken = ready_o;
    if (taken) begin
      e.op = op;
      e.mode = mode;
      e.result = model_result(op, mode, a, b, c);
      e.cmp = model_cmp(op, mode, a, b);
      e.has_cmp = is_cmp_op(op);
      e.accepted = cycle + 1;
      exp_q.push_back(e);
      issued++;
    end
    @(negedge clk);
    valid_i = 1'b0;
  endtask

  // retry with the same payload until accepted
  task automatic send(input alu_op_e op, input vec_mode_e mode, input logic [XLEN-1:0] a,
                      input logic [XLEN-1:0] b, input logic [XLEN-1:0] c);
    bit taken;
    taken = 1'b0;
    while (!taken) drive_op(op, mode, a, b, c, taken);
  endtask

  task automatic take_result;
    expect_t e;
    if (exp_q.size() == 0) begin
      errors++;
      $display("ERROR: result %h appeared with no operation outstanding", result_o);
    end else begin
      e = exp_q.pop_front();
      results_seen++;
      check_word($sformatf("result_o %s %s", e.op.name(), e.mode.name()), result_o, e.result);
      if (e.has_cmp) check_bit($sformatf("cmp_o %s %s", e.op.name(), e.mode.name()), cmp_o, e.cmp);
      // taken on the coming edge, two edges after the accepting one
      if (check_latency && cycle + 1 != e.accepted + 2) begin
        errors++;
        $display("ERROR: %s result came %0d cycles after acceptance instead of 2",
                 e.op.name(), cycle + 1 - e.accepted);
      end
    end
  endtask

  // handshake seen mid cycle, taken on the next rising edge
  always begin
    @(negedge clk);
    #1;
    if (arst_n && result_valid_o && result_ready_i) take_result();
  end

  task automatic drain;
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  // random rows, then edge rows, equal operands, sign bit only difference
  task automatic run_group(input alu_op_e op, input vec_mode_e mode);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] c;
    for (int n = 0; n < ROWS; n++) begin
      a = $random(seed);
      b = $random(seed);
      c = $random(seed);
      // odd rows tie the upper bytes so low bytes decide
      if (n % 2 == 1) b[31:8] = a[31:8];
      if (n >= RAND_N && n < RAND_N + 5) begin
        a = edge_a[n-RAND_N];
        b = edge_b[n-RAND_N];
        c = edge_c[n-RAND_N];
      end else if (n == RAND_N + 5) begin
        b = a;
      end else if (n == RAND_N + 6) begin
        b = a ^ lane_sign_bits(mode);
      end
      send(op, mode, a, b, c);
    end
  endtask

  task automatic test_reset_state;
    check_bit("result_valid_o", result_valid_o, 1'b0);
    check_bit("ready_o", ready_o, 1'b1);
  endtask

  task automatic test_add_sub;
    for (int m = 0; m < 3; m++) begin
      run_group(ALU_ADD, vec_mode_e'(m == 0 ? VEC_MODE32 : m == 1 ? VEC_MODE16 : VEC_MODE8));
      run_group(ALU_SUB, vec_mode_e'(m == 0 ? VEC_MODE32 : m == 1 ? VEC_MODE16 : VEC_MODE8));
    end
    drain();
  endtask

  task automatic test_logic_relu;
    vec_mode_e mode;
    for (int m = 0; m < 3; m++) begin
      mode = (m == 0) ? VEC_MODE32 : (m == 1) ? VEC_MODE16 : VEC_MODE8;
      for (int o = ALU_AND; o <= ALU_XOR; o++) run_group(alu_op_e'(o), mode);
      run_group(ALU_RELU, mode);
    end
    drain();
  endtask

  // vector compares, set-less-than and min/max
  task automatic test_compare;
    vec_mode_e mode;
    for (int m = 0; m < 3; m++) begin
      mode = (m == 0) ? VEC_MODE32 : (m == 1) ? VEC_MODE16 : VEC_MODE8;
      for (int o = ALU_EQ; o <= ALU_MAXU; o++) run_group(alu_op_e'(o), mode);
    end
    drain();
  endtask

  task automatic test_mac;
    run_group(ALU_MAC32, VEC_MODE32);
    run_group(ALU_MAC16, VEC_MODE16);
    drain();
  endtask

  // operands depend on the item index, so a retried item stays stable
  task automatic test_backpressure;
    int taken_n;
    bit taken;
    check_latency = 1'b0;
    result_ready_i = 1'b0;
    taken_n = 0;
    repeat (4) begin
      drive_op((taken_n % 2) ? ALU_MAC16 : ALU_SUB, VEC_MODE16, 32'h1111_1111 * (taken_n + 1),
               32'h0F0F_7FFF, 32'h8000_0001, taken);
      if (taken) taken_n++;
    end
    #1;
    check_bit("ready_o", ready_o, 1'b0);
    check_bit("result_valid_o", result_valid_o, 1'b1);
    if (taken_n != 2) begin
      errors++;
      $display("ERROR: %0d operations accepted under back-pressure, expected 2", taken_n);
    end
    @(negedge clk);
    result_ready_i = 1'b1;
    while (taken_n < BP_OPS) begin
      send((taken_n % 2) ? ALU_MAC16 : ALU_SUB, VEC_MODE16, 32'h1111_1111 * (taken_n + 1),
           32'h0F0F_7FFF, 32'h8000_0001);
      taken_n++;
    end
    drain();
    check_latency = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence and timeout
  ////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    arst_n = 1'b0;
    valid_i = 1'b0;
    op_i = ALU_ADD;
    vec_mode_i = VEC_MODE32;
    operand_a_i = '0;
    operand_b_i = '0;
    operand_c_i = '0;
    result_ready_i = 1'b1;
    seed = 1;
    // reset over four rising edges, released on a falling edge
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    test_reset_state();
    test_add_sub();
    test_logic_relu();
    test_compare();
    test_mac();
    test_backpressure();
    if (results_seen != issued) begin
      errors++;
      $display("ERROR: %0d operations issued but %0d results seen", issued, results_seen);
    end
    $display("errors %0d, checks %0d, operations %0d", errors, checks, issued);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    wait (cycle >= TIMEOUT_CYCLES);
    $display("ERROR: timeout after %0d cycles, %0d results still outstanding",
             cycle, exp_q.size());
    $display("errors %0d, checks %0d, operations %0d", errors, checks, issued);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+verification
source/simd_alu_pkg.sv
source/simd_alu_stage_if.sv
source/simd_adder.sv
source/simd_compare.sv
source/simd_issue_stage.sv
source/simd_accumulate_stage.sv
source/simd_alu_top.sv
verification/tb_simd_alu.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_simd_alu
FILELIST  := files.f
OBJ_DIR   := obj_dir
SIM_BIN   := ./$(OBJ_DIR)/V$(TOP)
PASS_MSG  := STATUS: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
